/* design/dmmu_ifs.sv */
// stage interfaces of the data MMU pipeline
// tlb_lookup_if (stage 1 to 2) and xlate_if (stage 2 to 3)

`include "dmmu_settings.svh"

// combinational lookup result, valid whenever a request is accepted
interface tlb_lookup_if;
    import dmmu_pkg::*;

    logic                     hit;
    logic                     is_4m;
    pte_t                     pte;
    // address the lookup was done for
    logic [`DMMU_VADDR_W-1:0] vaddr;

    modport lookup (
        output hit, is_4m, pte, vaddr
    );

    modport check (
        input hit, is_4m, pte, vaddr
    );
endinterface

// valid/ready channel, payload held while valid and not ready
interface xlate_if;
    import dmmu_pkg::*;

    logic                     valid;
    logic                     ready;
    logic [`DMMU_PADDR_W-1:0] paddr;
    mem_op_e                  op;
    logic [3:0]               sel;
    logic [31:0]              wdata;
    // a faulting item carries no bus access
    exc_t                     exc;

    modport src (
        output valid, paddr, op, sel, wdata, exc,
        input  ready
    );

    modport dst (
        input  valid, paddr, op, sel, wdata, exc,
        output ready
    );
endinterface

/* design/dmmu_pkg.sv */
// data MMU types: privilege, cause and opcode enums
// PTE, TLB entry and exception structs

`include "dmmu_settings.svh"

package dmmu_pkg;

    // ----------------------------------------------------------------------
    // enums
    // ----------------------------------------------------------------------

    // effective privilege of the load/store
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01
    } priv_lvl_e;

    // mcause encodings of the two data page faults
    typedef enum logic [4:0] {
        LOAD_PAGE_FAULT  = 5'd13,
        STORE_PAGE_FAULT = 5'd15
    } exc_cause_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    // ----------------------------------------------------------------------
    // structs
    // ----------------------------------------------------------------------

    // leaf PTE, only the bits the data side looks at
    typedef struct packed {
        logic [`DMMU_PPN_W-1:0] ppn;
        logic                   u;
        logic                   w;
        logic                   d;
    } pte_t;

    typedef struct packed {
        logic                    valid;
        logic [`DMMU_ASID_W-1:0] asid;
        logic [`DMMU_VPN_W-1:0]  vpn;
        // superpage, low vpn bits are don't care
        logic                    is_4m;
        pte_t                    pte;
    } tlb_entry_t;

    // tval carries the faulting virtual address
    typedef struct packed {
        logic                     valid;
        exc_cause_e               cause;
        logic [`DMMU_VADDR_W-1:0] tval;
    } exc_t;

endpackage

/* design/dmmu_settings.svh */
// data MMU build settings
// TLB size, ASID width and the Sv32 address field widths

`ifndef DMMU_SETTINGS_SVH
`define DMMU_SETTINGS_SVH

// number of data TLB entries
`define DMMU_TLB_ENTRIES 4

// address space identifier width
`define DMMU_ASID_W 9

// virtual and physical address widths
`define DMMU_VADDR_W 32
`define DMMU_PADDR_W 34

// page number and offset fields
`define DMMU_PPN_W 22
`define DMMU_VPN_W 20
`define DMMU_OFFSET_W 12

// vpn bits that a 4 MiB superpage takes from the virtual address
`define DMMU_SUPER_W 10

`endif

/* design/dmmu_top.sv */
// data MMU top level
// dtlb, xlate_check and wb_data_port joined by the stage interfaces

`include "dmmu_settings.svh"

module dmmu_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // translation control
    input  logic                     en_translation_i,
    input  dmmu_pkg::priv_lvl_e      priv_lvl_i,
    input  logic                     sum_i,
    input  logic [`DMMU_ASID_W-1:0]  asid_i,
    input  logic                     flush_i,
    // TLB write port
    input  logic                     tlb_we_i,
    input  logic [`DMMU_VPN_W-1:0]   tlb_vpn_i,
    input  logic [`DMMU_PPN_W-1:0]   tlb_ppn_i,
    input  logic                     tlb_is_4m_i,
    input  logic                     tlb_u_i,
    input  logic                     tlb_w_i,
    input  logic                     tlb_d_i,
    // load/store request
    input  logic                     lsu_req_i,
    output logic                     lsu_gnt_o,
    input  dmmu_pkg::mem_op_e        lsu_op_i,
    input  logic [`DMMU_VADDR_W-1:0] lsu_vaddr_i,
    input  logic [3:0]               lsu_sel_i,
    input  logic [31:0]              lsu_wdata_i,
    // load/store response
    output logic                     lsu_rvalid_o,
    output logic                     lsu_exc_valid_o,
    output dmmu_pkg::exc_cause_e     lsu_exc_cause_o,
    output logic [31:0]              lsu_exc_tval_o,
    output logic [31:0]              lsu_rdata_o,
    // Wishbone classic master
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output logic [`DMMU_PADDR_W-1:0] wb_adr_o,
    output logic [3:0]               wb_sel_o,
    output logic [31:0]              wb_dat_o,
    input  logic [31:0]              wb_dat_i,
    input  logic                     wb_ack_i
);
    import dmmu_pkg::*;

    tlb_entry_t tlb_wr_entry;

    tlb_lookup_if u_lookup_if ();
    xlate_if      u_xlate_if ();

    // written entries are always valid and tagged with the current ASID
    always_comb begin
        tlb_wr_entry.valid     = 1'b1;
        tlb_wr_entry.asid      = asid_i;
        tlb_wr_entry.vpn       = tlb_vpn_i;
        tlb_wr_entry.is_4m     = tlb_is_4m_i;
        tlb_wr_entry.pte.ppn   = tlb_ppn_i;
        tlb_wr_entry.pte.u     = tlb_u_i;
        tlb_wr_entry.pte.w     = tlb_w_i;
        tlb_wr_entry.pte.d     = tlb_d_i;
    end

    // ----------------------------------------------------------------------
    // pipeline stages
    // ----------------------------------------------------------------------

    dtlb #(
        .TLB_ENTRIES ( `DMMU_TLB_ENTRIES )
    ) u_dtlb (
        .clk_i      ( clk_i        ),
        .rst_ni     ( rst_ni       ),
        .flush_i    ( flush_i      ),
        .wr_en_i    ( tlb_we_i     ),
        .wr_entry_i ( tlb_wr_entry ),
        .lu_asid_i  ( asid_i       ),
        .lu_vaddr_i ( lsu_vaddr_i  ),
        .lu         ( u_lookup_if  )
    );

    xlate_check u_xlate_check (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .en_translation_i ( en_translation_i ),
        .priv_lvl_i       ( priv_lvl_i       ),
        .sum_i            ( sum_i            ),
        .req_i            ( lsu_req_i        ),
        .gnt_o            ( lsu_gnt_o        ),
        .op_i             ( lsu_op_i         ),
        .sel_i            ( lsu_sel_i        ),
        .wdata_i          ( lsu_wdata_i      ),
        .lu               ( u_lookup_if      ),
        .out              ( u_xlate_if       )
    );

    wb_data_port u_wb_data_port (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .in              ( u_xlate_if      ),
        .wb_cyc_o        ( wb_cyc_o        ),
        .wb_stb_o        ( wb_stb_o        ),
        .wb_we_o         ( wb_we_o         ),
        .wb_adr_o        ( wb_adr_o        ),
        .wb_sel_o        ( wb_sel_o        ),
        .wb_dat_o        ( wb_dat_o        ),
        .wb_dat_i        ( wb_dat_i        ),
        .wb_ack_i        ( wb_ack_i        ),
        .lsu_rvalid_o    ( lsu_rvalid_o    ),
        .lsu_exc_valid_o ( lsu_exc_valid_o ),
        .lsu_exc_cause_o ( lsu_exc_cause_o ),
        .lsu_exc_tval_o  ( lsu_exc_tval_o  ),
        .lsu_rdata_o     ( lsu_rdata_o     )
    );

endmodule

/* design/dtlb.sv */
// fully associative data TLB, stage 1 of the data MMU
// software filled through a write port, round-robin replacement

`include "dmmu_settings.svh"

module dtlb #(
    parameter int unsigned TLB_ENTRIES = `DMMU_TLB_ENTRIES
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     wr_en_i,
    input  dmmu_pkg::tlb_entry_t     wr_entry_i,
    input  logic [`DMMU_ASID_W-1:0]  lu_asid_i,
    input  logic [`DMMU_VADDR_W-1:0] lu_vaddr_i,
    tlb_lookup_if.lookup             lu
);
    import dmmu_pkg::*;

    localparam int unsigned VPN_W = `DMMU_VPN_W;
    // vpn bits a superpage ignores
    localparam int unsigned LO_W  = `DMMU_VPN_W - `DMMU_SUPER_W;
    localparam int unsigned PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    // entry payload, valid bits kept apart
    tlb_entry_t             entries_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid_q;
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [TLB_ENTRIES-1:0] match;
    logic [VPN_W-1:0]       lu_vpn;

    assign lu_vpn   = lu_vaddr_i[`DMMU_VADDR_W-1:`DMMU_OFFSET_W];
    assign lu.vaddr = lu_vaddr_i;

    // ----------------------------------------------------------------------
    // lookup
    // ----------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            // upper vpn always compared, lower part only for 4 KiB pages
            match[i] = valid_q[i]
                && (entries_q[i].asid == lu_asid_i)
                && (entries_q[i].vpn[VPN_W-1:LO_W] == lu_vpn[VPN_W-1:LO_W])
                && (entries_q[i].is_4m
                    || (entries_q[i].vpn[LO_W-1:0] == lu_vpn[LO_W-1:0]));
        end
    end

    // at most one entry matches, so a plain select is enough
    always_comb begin
        lu.hit   = 1'b0;
        lu.is_4m = 1'b0;
        lu.pte   = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                lu.hit   = 1'b1;
                lu.is_4m = entries_q[i].is_4m;
                lu.pte   = entries_q[i].pte;
            end
        end
    end

    // ----------------------------------------------------------------------
    // fill and flush
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            entries_q[wr_ptr_q] <= wr_entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
        end else begin
            if (flush_i) begin
                valid_q <= '0;
            end
            // a write in the flush cycle survives the flush
            if (wr_en_i) begin
                valid_q[wr_ptr_q] <= wr_entry_i.valid;
                if (wr_ptr_q == PTR_W'(TLB_ENTRIES - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
        end
    end

    // software must not map one page twice
    a_single_match: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(match)
    );

endmodule

/* design/wb_data_port.sv */
// stage 3 of the data MMU: Wishbone classic master
// plus the response register towards the load/store unit

`include "dmmu_settings.svh"

module wb_data_port (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    xlate_if.dst                     in,
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output logic [`DMMU_PADDR_W-1:0] wb_adr_o,
    output logic [3:0]               wb_sel_o,
    output logic [31:0]              wb_dat_o,
    input  logic [31:0]              wb_dat_i,
    input  logic                     wb_ack_i,
    output logic                     lsu_rvalid_o,
    output logic                     lsu_exc_valid_o,
    output dmmu_pkg::exc_cause_e     lsu_exc_cause_o,
    output logic [31:0]              lsu_exc_tval_o,
    output logic [31:0]              lsu_rdata_o
);
    import dmmu_pkg::*;

    typedef enum logic {
        IDLE,
        BUS
    } state_e;

    state_e state_q;
    logic   take;
    logic   done;

    // one item at a time, no new item until the bus cycle ends
    assign in.ready = (state_q == IDLE);
    assign take     = in.valid && in.ready;
    assign done     = (state_q == BUS) && wb_ack_i;

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q         <= IDLE;
            wb_cyc_o        <= 1'b0;
            wb_stb_o        <= 1'b0;
            wb_we_o         <= 1'b0;
            lsu_rvalid_o    <= 1'b0;
            lsu_exc_valid_o <= 1'b0;
        end else begin
            // response pulses last one cycle
            lsu_rvalid_o    <= 1'b0;
            lsu_exc_valid_o <= 1'b0;
            if (take && in.exc.valid) begin
                // fault, answer right away without a bus cycle
                lsu_rvalid_o    <= 1'b1;
                lsu_exc_valid_o <= 1'b1;
            end else if (take) begin
                state_q  <= BUS;
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
                wb_we_o  <= (in.op == OP_STORE);
            end
            // classic cycle ends on ack, cyc stays low for a cycle after
            if (done) begin
                state_q      <= IDLE;
                wb_cyc_o     <= 1'b0;
                wb_stb_o     <= 1'b0;
                wb_we_o      <= 1'b0;
                lsu_rvalid_o <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // bus and response payload
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (take) begin
            wb_adr_o        <= in.paddr;
            wb_sel_o        <= in.sel;
            wb_dat_o        <= in.wdata;
            lsu_exc_cause_o <= in.exc.cause;
            lsu_exc_tval_o  <= in.exc.tval;
        end
        if (done) begin
            lsu_rdata_o <= wb_dat_i;
        end
    end

    // stb never raised on its own or outside a cycle
    a_stb_with_cyc: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(wb_stb_o) |-> $rose(wb_cyc_o)
    );

    // address held until the slave acks
    a_adr_hold: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o)
    );

endmodule

/* design/xlate_check.sv */
// stage 2 of the data MMU: request register, physical address
// formation and Sv32 privilege checks

`include "dmmu_settings.svh"

module xlate_check (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                en_translation_i,
    input  dmmu_pkg::priv_lvl_e priv_lvl_i,
    input  logic                sum_i,
    input  logic                req_i,
    output logic                gnt_o,
    input  dmmu_pkg::mem_op_e   op_i,
    input  logic [3:0]          sel_i,
    input  logic [31:0]         wdata_i,
    tlb_lookup_if.check         lu,
    xlate_if.src                out
);
    import dmmu_pkg::*;

    localparam int unsigned PAD_W = `DMMU_PADDR_W - `DMMU_VADDR_W;
    // paddr bits that a superpage takes from the vaddr
    localparam int unsigned SP_HI = `DMMU_OFFSET_W + `DMMU_VPN_W - `DMMU_SUPER_W - 1;
    localparam int unsigned SP_LO = `DMMU_OFFSET_W;

    logic                     accept;
    logic                     priv_err;
    logic                     fault;
    logic [`DMMU_PADDR_W-1:0] paddr_d;
    exc_t                     exc_d;

    logic                     valid_q;
    logic [`DMMU_PADDR_W-1:0] paddr_q;
    mem_op_e                  op_q;
    logic [3:0]               sel_q;
    logic [31:0]              wdata_q;
    exc_t                     exc_q;

    // room when empty or when the item leaves this cycle
    assign gnt_o  = !valid_q || out.ready;
    assign accept = req_i && gnt_o;

    // ----------------------------------------------------------------------
    // translation and checks on the incoming request
    // ----------------------------------------------------------------------

    always_comb begin
        // bare mode, zero extended vaddr and no checks
        paddr_d  = {{PAD_W{1'b0}}, lu.vaddr};
        priv_err = 1'b0;
        fault    = 1'b0;
        if (en_translation_i) begin
            // 4 KiB page
            paddr_d = {lu.pte.ppn, lu.vaddr[`DMMU_OFFSET_W-1:0]};
            // 4 MiB superpage
            if (lu.is_4m) begin
                paddr_d[SP_HI:SP_LO] = lu.vaddr[SP_HI:SP_LO];
            end
            // user page from S only with SUM, supervisor page never from U
            priv_err = ((priv_lvl_i == PRIV_U) && !lu.pte.u)
                    || ((priv_lvl_i == PRIV_S) && lu.pte.u && !sum_i);
            fault = !lu.hit || priv_err
                 || ((op_i == OP_STORE) && (!lu.pte.w || !lu.pte.d));
        end
        exc_d.valid = fault;
        exc_d.cause = (op_i == OP_STORE) ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        exc_d.tval  = lu.vaddr;
    end

    // ----------------------------------------------------------------------
    // stage register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (gnt_o) begin
            valid_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            paddr_q <= paddr_d;
            op_q    <= op_i;
            sel_q   <= sel_i;
            wdata_q <= wdata_i;
            exc_q   <= exc_d;
        end
    end

    assign out.valid = valid_q;
    assign out.paddr = paddr_q;
    assign out.op    = op_q;
    assign out.sel   = sel_q;
    assign out.wdata = wdata_q;
    assign out.exc   = exc_q;

    // item held steady under back-pressure from stage 3
    a_hold_stalled: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        out.valid && !out.ready |=> out.valid && $stable(out.paddr)
            && $stable(out.op) && $stable(out.sel) && $stable(out.wdata)
            && $stable(out.exc)
    );

endmodule

/* verif/dmmu_tb.sv */
// data MMU testbench: stimulus, Wishbone slave model,
// expected-response queue, protocol assertions and report

`include "dmmu_settings.svh"

module dmmu_tb;
    import dmmu_pkg::*;

    localparam int DRIVE      = 5;
    localparam int TLB_N      = `DMMU_TLB_ENTRIES;
    // about 80 requests at up to 10 cycles each, plus TLB setup
    localparam int MAX_CYCLES = 1200;

    // one expected response, pushed when the request is accepted
    typedef struct {
        logic        store;
        logic        exc;
        logic [33:0] paddr;
        logic [3:0]  sel;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] tval;
    } exp_t;

    logic clk_i;
    logic rst_ni;
    logic en_translation_i;
    priv_lvl_e priv_lvl_i;
    logic sum_i;
    logic [8:0] asid_i;
    logic flush_i;
    logic tlb_we_i;
    logic [19:0] tlb_vpn_i;
    logic [21:0] tlb_ppn_i;
    logic tlb_is_4m_i;
    logic tlb_u_i;
    logic tlb_w_i;
    logic tlb_d_i;
    logic lsu_req_i;
    logic lsu_gnt_o;
    mem_op_e lsu_op_i;
    logic [31:0] lsu_vaddr_i;
    logic [3:0] lsu_sel_i;
    logic [31:0] lsu_wdata_i;
    logic lsu_rvalid_o;
    logic lsu_exc_valid_o;
    exc_cause_e lsu_exc_cause_o;
    logic [31:0] lsu_exc_tval_o;
    logic [31:0] lsu_rdata_o;
    logic wb_cyc_o;
    logic wb_stb_o;
    logic wb_we_o;
    logic [33:0] wb_adr_o;
    logic [3:0] wb_sel_o;
    logic [31:0] wb_dat_o;
    logic [31:0] wb_dat_i;
    logic wb_ack_i;

    // testbench copy of the TLB and the two memories
    tlb_entry_t  m_tlb [TLB_N];
    int          m_ptr;
    logic [31:0] bus_mem [logic [33:0]];
    logic [31:0] ref_mem [logic [33:0]];
    exp_t        exp_q [$];
    exp_t        head;
    logic [33:0] slave_key;
    logic        ack_busy;
    int          ack_wait;
    logic        cyc_seen;
    logic [31:0] rnd;
    logic [19:0] pages [6] = '{20'h00010, 20'h00011, 20'h00012, 20'h00020,
                               20'h12345, 20'h70000};
    int cycles;
    int in_flight;
    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int test_err_start;

    dmmu_top u_dmmu_top (.*);

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    // power-on memory content, mixes every address bit
    function automatic logic [31:0] fill_word(logic [33:0] a);
        return a[33:2] ^ {a[11:2], a[33:12]} ^ 32'h6d2e_19c3;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] nw,
                                                logic [3:0] sel);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                r[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic report_failure(string msg);
        $display("error at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] got);
        if (exp !== got) begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    // expected response from the Sv32 rules and the TLB copy
    task automatic predict(mem_op_e op, logic [31:0] va, logic [3:0] sel, logic [31:0] wd);
        exp_t        e;
        tlb_entry_t  t;
        logic        hit;
        logic [33:0] key;
        e.store = (op == OP_STORE);
        e.exc   = 1'b0;
        e.paddr = {2'b00, va};
        e.sel   = sel;
        e.wdata = wd;
        e.tval  = va;
        e.rdata = '0;
        if (en_translation_i) begin
            hit = 1'b0;
            t   = '0;
            for (int i = 0; i < TLB_N; i++) begin
                if (m_tlb[i].valid && m_tlb[i].asid == asid_i
                        && m_tlb[i].vpn[19:10] == va[31:22]
                        && (m_tlb[i].is_4m || m_tlb[i].vpn[9:0] == va[21:12])) begin
                    hit = 1'b1;
                    t   = m_tlb[i];
                end
            end
            e.paddr = {t.pte.ppn, va[11:0]};
            if (t.is_4m) begin
                e.paddr[21:12] = va[21:12];
            end
            e.exc = !hit || (priv_lvl_i == PRIV_U && !t.pte.u)
                 || (priv_lvl_i == PRIV_S && t.pte.u && !sum_i)
                 || (e.store && !(t.pte.w && t.pte.d));
        end
        key = {e.paddr[33:2], 2'b00};
        if (!e.exc) begin
            e.rdata = ref_mem.exists(key) ? ref_mem[key] : fill_word(key);
            if (e.store) begin
                ref_mem[key] = merge_bytes(e.rdata, wd, sel);
            end
        end
        exp_q.push_back(e);
    endtask

    task automatic issue(mem_op_e op, logic [31:0] va, logic [3:0] sel, logic [31:0] wd);
        lsu_req_i   = 1'b1;
        lsu_op_i    = op;
        lsu_vaddr_i = va;
        lsu_sel_i   = sel;
        lsu_wdata_i = wd;
        // grant only depends on pipeline state, settled after the edge
        while (!lsu_gnt_o) begin
            @(posedge clk_i);
            #DRIVE;
        end
        predict(op, va, sel, wd);
        @(posedge clk_i);
        #DRIVE;
        lsu_req_i = 1'b0;
    endtask

    task automatic tlb_write(logic [19:0] vpn, logic [21:0] ppn, logic is_4m,
                             logic u, logic w, logic d);
        tlb_we_i    = 1'b1;
        tlb_vpn_i   = vpn;
        tlb_ppn_i   = ppn;
        tlb_is_4m_i = is_4m;
        tlb_u_i     = u;
        tlb_w_i     = w;
        tlb_d_i     = d;
        m_tlb[m_ptr] = {1'b1, asid_i, vpn, is_4m, ppn, u, w, d};
        m_ptr = (m_ptr + 1) % TLB_N;
        @(posedge clk_i);
        #DRIVE;
        tlb_we_i = 1'b0;
    endtask

    task automatic flush_tlb();
        flush_i = 1'b1;
        for (int i = 0; i < TLB_N; i++) begin
            m_tlb[i].valid = 1'b0;
        end
        @(posedge clk_i);
        #DRIVE;
        flush_i = 1'b0;
    endtask

    // wait for every outstanding response, then score the test
    task automatic end_test(string name);
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #DRIVE;
        end
        if (err_cnt == test_err_start) begin
            pass_cnt++;
            $display("test %-12s ok", name);
        end else begin
            fail_cnt++;
            $display("test %-12s FAILED with %0d errors", name, err_cnt - test_err_start);
        end
        test_err_start = err_cnt;
    endtask

    // ------------------------------------------------------------------
    // Wishbone slave, acks after 0 to 3 wait cycles
    // ------------------------------------------------------------------

    always @(posedge clk_i) begin
        #DRIVE;
        if (wb_ack_i) begin
            wb_ack_i = 1'b0;
            ack_busy = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!ack_busy) begin
                ack_busy = 1'b1;
                ack_wait = $urandom_range(3, 0);
            end
            if (ack_wait == 0) begin
                wb_ack_i  = 1'b1;
                slave_key = {wb_adr_o[33:2], 2'b00};
                wb_dat_i  = bus_mem.exists(slave_key) ? bus_mem[slave_key]
                                                      : fill_word(slave_key);
                if (wb_we_o) begin
                    bus_mem[slave_key] = merge_bytes(wb_dat_i, wb_dat_o, wb_sel_o);
                end
            end else begin
                ack_wait--;
            end
        end
    end

    // accepted requests, counted at the accepting edge
    always @(posedge clk_i) begin
        if (lsu_req_i && lsu_gnt_o) begin
            in_flight++;
        end
    end

    // ------------------------------------------------------------------
    // response and bus monitor, samples mid-cycle
    // ------------------------------------------------------------------

    always @(negedge clk_i) begin
        if (rst_ni) begin
            // new bus cycle belongs to the oldest outstanding request
            if (wb_cyc_o && !cyc_seen) begin
                if (exp_q.size() == 0) begin
                    report_failure("bus cycle started with no request outstanding");
                end else begin
                    if (exp_q[0].exc) begin
                        report_failure("bus cycle started for a faulting access");
                    end
                    check_value("wb_adr_o", exp_q[0].paddr, wb_adr_o);
                    check_value("wb_we_o", exp_q[0].store, wb_we_o);
                    check_value("wb_sel_o", exp_q[0].sel, wb_sel_o);
                    if (exp_q[0].store) begin
                        check_value("wb_dat_o", exp_q[0].wdata, wb_dat_o);
                    end
                end
            end
            cyc_seen = wb_cyc_o;
            if (lsu_rvalid_o) begin
                if (exp_q.size() == 0) begin
                    report_failure("response came with no request outstanding");
                end else begin
                    head = exp_q.pop_front();
                    in_flight--;
                    check_value("lsu_exc_valid_o", head.exc, lsu_exc_valid_o);
                    if (head.exc) begin
                        check_value("lsu_exc_cause_o",
                            head.store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT, lsu_exc_cause_o);
                        check_value("lsu_exc_tval_o", head.tval, lsu_exc_tval_o);
                    end else if (!head.store) begin
                        check_value("lsu_rdata_o", head.rdata, lsu_rdata_o);
                    end
                end
            end
            // two unanswered items fill stage 2 and stage 3, so no room
            check_value("lsu_gnt_o", in_flight < 2, lsu_gnt_o);
        end
    end

    // Wishbone classic hold and release rules
    a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o)
            && $stable(wb_sel_o) && $stable(wb_dat_o))
        else report_failure("wishbone request changed or dropped before ack");
    a_wb_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_cyc_o && wb_ack_i |=> !wb_cyc_o && !wb_stb_o)
        else report_failure("wishbone cycle not released after ack");
    a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_stb_o == wb_cyc_o)
        else report_failure("stb and cyc differ");
    a_fault_no_bus: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_exc_valid_o |-> lsu_rvalid_o && !wb_cyc_o)
        else report_failure("fault response without rvalid or during a bus cycle");

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------

    initial begin
        void'($urandom(32'h1b22_444d));
        clk_i = 1'b0;
        rst_ni = 1'b0;
        en_translation_i = 1'b0;
        priv_lvl_i = PRIV_S;
        sum_i = 1'b0;
        asid_i = 9'd1;
        flush_i = 1'b0;
        tlb_we_i = 1'b0;
        tlb_vpn_i = '0;
        tlb_ppn_i = '0;
        tlb_is_4m_i = 1'b0;
        tlb_u_i = 1'b0;
        tlb_w_i = 1'b0;
        tlb_d_i = 1'b0;
        lsu_req_i = 1'b0;
        lsu_op_i = OP_LOAD;
        lsu_vaddr_i = '0;
        lsu_sel_i = '0;
        lsu_wdata_i = '0;
        wb_dat_i = '0;
        wb_ack_i = 1'b0;
        ack_busy = 1'b0;
        cyc_seen = 1'b0;
        m_ptr = 0;
        for (int i = 0; i < TLB_N; i++) begin
            m_tlb[i] = '0;
        end
        repeat (8) @(posedge clk_i);
        #DRIVE;
        rst_ni = 1'b1;

        // bare mode, zero extended addresses
        issue(OP_STORE, 32'h0000_1000, 4'hf, 32'hcafe_0001);
        issue(OP_LOAD, 32'h0000_1000, 4'hf, '0);
        issue(OP_STORE, 32'hffff_fffc, 4'b0110, 32'h1234_5678);
        issue(OP_LOAD, 32'hffff_fffc, 4'hf, '0);
        issue(OP_LOAD, 32'h8000_0010, 4'hf, '0);
        end_test("bare_mode");

        // 4 KiB page and 4 MiB superpage, low ppn bits of the superpage ignored
        en_translation_i = 1'b1;
        tlb_write(20'h12345, 22'h2a_bcde, 1'b0, 1'b0, 1'b1, 1'b1);
        tlb_write(20'hc0155, 22'h3f_f3a5, 1'b1, 1'b0, 1'b1, 1'b1);
        issue(OP_STORE, 32'h1234_5678, 4'hf, 32'h0bad_f00d);
        issue(OP_LOAD, 32'h1234_5678, 4'hf, '0);
        issue(OP_LOAD, 32'hc02a_b5c8, 4'hf, '0);
        issue(OP_STORE, 32'hc03f_f004, 4'b1001, 32'h5566_7788);
        issue(OP_LOAD, 32'hc03f_f004, 4'hf, '0);
        end_test("page_xlate");

        // misses: unmapped, other ASID, flushed
        issue(OP_LOAD, 32'h7000_0040, 4'hf, '0);
        issue(OP_STORE, 32'h7000_0044, 4'hf, 32'h1);
        asid_i = 9'd2;
        issue(OP_LOAD, 32'h1234_5678, 4'hf, '0);
        asid_i = 9'd1;
        flush_tlb();
        issue(OP_LOAD, 32'h1234_5678, 4'hf, '0);
        issue(OP_STORE, 32'hc02a_b5c8, 4'hf, 32'h2);
        end_test("tlb_miss");

        // read-only, clean, user and supervisor pages
        tlb_write(20'h00010, 22'h00_0110, 1'b0, 1'b0, 1'b0, 1'b1);
        tlb_write(20'h00011, 22'h00_0111, 1'b0, 1'b0, 1'b1, 1'b0);
        tlb_write(20'h00020, 22'h00_0220, 1'b0, 1'b1, 1'b1, 1'b1);
        tlb_write(20'h00012, 22'h00_0112, 1'b0, 1'b0, 1'b1, 1'b1);
        issue(OP_STORE, 32'h0001_0004, 4'hf, 32'h3);
        issue(OP_LOAD, 32'h0001_0004, 4'hf, '0);
        issue(OP_STORE, 32'h0001_1008, 4'hf, 32'h4);
        priv_lvl_i = PRIV_U;
        issue(OP_LOAD, 32'h0001_2000, 4'hf, '0);
        issue(OP_STORE, 32'h0002_0010, 4'hf, 32'h9abc_def0);
        issue(OP_LOAD, 32'h0002_0010, 4'hf, '0);
        priv_lvl_i = PRIV_S;
        issue(OP_LOAD, 32'h0002_0010, 4'hf, '0);
        sum_i = 1'b1;
        issue(OP_LOAD, 32'h0002_0010, 4'hf, '0);
        issue(OP_STORE, 32'h0002_0014, 4'b0011, 32'h7777_1111);
        end_test("permissions");

        // back to back random mix, ordering under random ack delay
        for (int n = 0; n < 40; n++) begin
            rnd = $urandom;
            priv_lvl_i = rnd[0] ? PRIV_U : PRIV_S;
            sum_i = rnd[1];
            issue(rnd[2] ? OP_STORE : OP_LOAD,
                  {pages[$urandom_range(5, 0)], rnd[13:4], 2'b00}, rnd[19:16], $urandom);
        end
        end_test("random_mix");

        $display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
design/dmmu_pkg.sv
design/dmmu_ifs.sv
design/dtlb.sv
design/xlate_check.sv
design/wb_data_port.sv
design/dmmu_top.sv
verif/dmmu_tb.sv
